// ==== flist.f ====
hw/sync_adjust_pkg.sv
hw/estimate_if.sv
hw/cycle_estimator.sv
hw/drift_estimator.sv
hw/adjust_report.sv
hw/sync_adjust_top.sv
sim/tb_clock.sv
sim/sync_adjust_properties.sv
sim/tb_sync_adjust.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_sync_adjust \
		-f flist.f -Mdir obj_dir
	./obj_dir/Vtb_sync_adjust > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_sync_adjust.sv ====
// package default widths only and every report is due ESTIMATE_LATENCY+1 cycles after its strobe
`timescale 1ns/1ps

module tb_sync_adjust;

    localparam int TW = sync_adjust_pkg::TIMER_WIDTH_DEFAULT;
    localparam int EW = sync_adjust_pkg::ERROR_WIDTH_DEFAULT + sync_adjust_pkg::ERROR_Q;
    localparam int CB = sync_adjust_pkg::CYCLE_WIDTH_DEFAULT + sync_adjust_pkg::LPF_GAIN_CYCLE;
    localparam int GC = sync_adjust_pkg::LPF_GAIN_CYCLE;
    localparam int GX = sync_adjust_pkg::LPF_GAIN_PHASE;
    localparam int GV = sync_adjust_pkg::LPF_GAIN_PERIOD;
    localparam int REPORT_DELAY  = sync_adjust_pkg::ESTIMATE_LATENCY + 1;
    localparam int CLK_PERIOD_NS = 8;
    localparam int GAP_MIN = 8;
    localparam int GAP_MAX = 40;
    // strobes per test
    localparam int N_CYCLE    = 30;
    localparam int N_PHASE    = 60;
    localparam int N_OVERRIDE = 4;
    localparam int N_SETTLE   = 200;
    localparam int N_TOTAL    = 1 + N_CYCLE + N_PHASE + N_OVERRIDE + 1 + N_SETTLE;
    // every strobe at its longest gap plus idle and margin
    localparam int WATCHDOG_CYCLES = N_TOTAL * GAP_MAX + 100;

    logic          clk;
    logic          reset;
    logic          correct_valid;
    logic          correct_override;
    logic [TW-1:0] correct_time;
    logic [TW-1:0] current_time;
    logic          adjust_sign;
    logic          adjust_zero;
    logic [EW-1:0] adjust_error;
    logic [CB-1:0] adjust_cycle;
    logic          adjust_valid;

    integer seed;
    string  test_name;
    int     test_errors;
    int     total_errors;
    int     check_count;
    int     test_count;
    // local time in cycles and the cycle of the last strobe
    int     step_count;
    int     last_strobe;

    // cycle filter model
    logic          cyc_armed;
    logic          cyc_ok;
    logic [CB-1:0] cyc_est;
    // phase and period model
    logic signed [EW-1:0] x_est;
    logic signed [EW-1:0] v_est;
    logic                 x_ok;
    logic                 v_ok;
    // last report of the model
    logic          pub_any;
    logic          pub_sign;
    logic          pub_zero;
    logic [EW-1:0] pub_error;
    logic [CB-1:0] pub_cycle;
    logic          expect_valid;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(4)) u_clock (.clk(clk), .reset(reset));

    sync_adjust_top UUT (
        .clk             (clk),
        .reset           (reset),
        .correct_valid   (correct_valid),
        .correct_override(correct_override),
        .correct_time    (correct_time),
        .current_time    (current_time),
        .adjust_sign     (adjust_sign),
        .adjust_zero     (adjust_zero),
        .adjust_error    (adjust_error),
        .adjust_cycle    (adjust_cycle),
        .adjust_valid    (adjust_valid)
    );

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    // one cycle with inputs changing 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
        step_count++;
        current_time = step_count;
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    function automatic int rand_gap();
        int r;
        r = $random(seed) % (GAP_MAX - GAP_MIN + 1);
        if (r < 0) begin
            r = -r;
        end
        return GAP_MIN + r;
    endfunction

    // phase offset within +-500
    function automatic int rand_offset();
        return $random(seed) % 501;
    endfunction

    // ----------------------------------------
    // reference model called once per strobe
    // ----------------------------------------

    task automatic model_strobe(input logic ovr, input int offset);
        logic signed [EW-1:0] obs_x;
        logic signed [EW-1:0] prev_x;
        logic signed [EW-1:0] prev_v;
        logic signed [EW-1:0] pred_x;
        logic signed [EW-1:0] obs_v;
        logic                 prev_x_ok;
        logic                 prev_v_ok;
        logic [CB-1:0]        obs_c;
        logic                 next_sign;
        logic                 next_zero;
        logic [EW-1:0]        next_error;
        logic [CB-1:0]        next_cycle;

        // interval since the previous strobe and nothing for the first
        if (cyc_armed) begin
            obs_c = CB'(step_count - last_strobe) << GC;
            if (cyc_ok) begin
                cyc_est = cyc_est - (cyc_est >> GC) + (obs_c >> GC);
            end else begin
                cyc_est = obs_c;
            end
            cyc_ok = 1'b1;
        end
        cyc_armed   = 1'b1;
        last_strobe = step_count;

        // override drops the history
        prev_x_ok = x_ok & ~ovr;
        prev_v_ok = v_ok & ~ovr;
        prev_x    = x_est;
        prev_v    = v_est;
        if (ovr) begin
            obs_x = '0;
        end else begin
            obs_x = EW'(offset);
            obs_x = obs_x <<< sync_adjust_pkg::ERROR_Q;
        end

        // phase blends prediction and observation
        if (prev_x_ok && prev_v_ok) begin
            pred_x = prev_x + prev_v;
            x_est  = pred_x - (pred_x >>> GX) + (obs_x >>> GX);
        end else begin
            x_est = obs_x;
        end
        x_ok = 1'b1;

        // period from successive phases
        obs_v = x_est - prev_x;
        if (prev_v_ok) begin
            v_est = prev_v - (prev_v >>> GV) + (obs_v >>> GV);
        end else begin
            v_est = obs_v;
        end
        v_ok = prev_x_ok;

        // report and change detection
        next_sign  = x_est[EW-1];
        next_zero  = (x_est == '0);
        next_error = next_sign ? -x_est : x_est;
        next_cycle = cyc_ok ? cyc_est : '0;
        expect_valid = !pub_any || (next_sign != pub_sign) || (next_zero != pub_zero)
                     || (next_error != pub_error) || (next_cycle != pub_cycle);
        pub_any   = 1'b1;
        pub_sign  = next_sign;
        pub_zero  = next_zero;
        pub_error = next_error;
        pub_cycle = next_cycle;
    endtask

    // strobe now and watch every cycle until the next strobe slot
    task automatic strobe(input logic ovr, input int offset, input int gap);
        correct_valid    = 1'b1;
        correct_override = ovr;
        correct_time     = current_time + TW'(offset);
        model_strobe(ovr, offset);
        for (int i = 1; i <= gap; i++) begin
            step();
            correct_valid    = 1'b0;
            correct_override = 1'b0;
            if (i == REPORT_DELAY) begin
                check("adjust_valid", 64'(expect_valid), 64'(adjust_valid));
                check("adjust_sign", 64'(pub_sign), 64'(adjust_sign));
                check("adjust_zero", 64'(pub_zero), 64'(adjust_zero));
                check("adjust_error", 64'(pub_error), 64'(adjust_error));
                check("adjust_cycle", 64'(pub_cycle), 64'(adjust_cycle));
            end else begin
                check("adjust_valid", 64'd0, 64'(adjust_valid));
            end
        end
    endtask

    task automatic end_test();
        test_count++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: passed", test_name);
        end else begin
            $display("%s: %0d mismatches", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    initial begin
        int offset;
        int gap;
        int mag;
        int quiet_run;
        int settle_count;

        seed             = 32'h4939a903;
        correct_valid    = 1'b0;
        correct_override = 1'b0;
        correct_time     = '0;
        current_time     = '0;
        test_errors  = 0;
        total_errors = 0;
        check_count  = 0;
        test_count   = 0;
        step_count   = 0;
        last_strobe  = 0;
        cyc_armed = 1'b0;
        cyc_ok    = 1'b0;
        cyc_est   = '0;
        x_est     = '0;
        v_est     = '0;
        x_ok      = 1'b0;
        v_ok      = 1'b0;
        pub_any   = 1'b0;
        pub_sign  = 1'b0;
        pub_zero  = 1'b0;
        pub_error = '0;
        pub_cycle = '0;
        expect_valid = 1'b0;
        @(negedge reset);

        // quiet after reset and then the first report always strobes
        test_name = "reset";
        repeat (10) begin
            step();
            check("adjust_valid", 64'd0, 64'(adjust_valid));
        end
        strobe(1'b0, rand_offset(), rand_gap());
        end_test();

        test_name = "cycle estimate";
        repeat (N_CYCLE) strobe(1'b0, rand_offset(), rand_gap());
        end_test();

        test_name = "phase and period";
        repeat (N_PHASE) strobe(1'b0, rand_offset(), rand_gap());
        end_test();

        // override reports zero and the next strobe is taken unfiltered
        test_name = "override";
        strobe(1'b0, rand_offset(), rand_gap());
        strobe(1'b1, rand_offset(), rand_gap());
        check("override zero", 64'd1, 64'(adjust_zero));
        check("override error", 64'd0, 64'(adjust_error));
        offset = rand_offset();
        mag    = (offset < 0) ? -offset : offset;
        strobe(1'b0, offset, rand_gap());
        check("pass-through error", 64'(mag) << sync_adjust_pkg::ERROR_Q, 64'(adjust_error));
        strobe(1'b0, rand_offset(), rand_gap());
        end_test();

        // identical strobes until the reports go quiet
        test_name = "change-only";
        gap    = rand_gap();
        offset = rand_offset() / 10;
        strobe(1'b1, 0, gap);
        quiet_run    = 0;
        settle_count = 0;
        while (quiet_run < 6 && settle_count < N_SETTLE) begin
            strobe(1'b0, offset, gap);
            settle_count++;
            if (expect_valid) begin
                quiet_run = 0;
            end else begin
                quiet_run++;
            end
        end
        if (quiet_run < 6) begin
            $display("change-only: reports kept changing after %0d identical strobes",
                     settle_count);
            test_errors++;
        end
        end_test();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== sim/sync_adjust_properties.sv ====
// checks only top-level strobe timing and assumes the default estimate latency of the package
`timescale 1ns/1ps

module sync_adjust_properties (
    input logic clk,
    input logic reset,
    input logic correct_valid,
    input logic adjust_valid
);

    localparam int REPORT_DELAY = sync_adjust_pkg::ESTIMATE_LATENCY + 1;

    // ----------------------------------------
    // strobe history
    // ----------------------------------------

    // bit k set when correct_valid was high k+1 cycles ago
    logic [6:0] recent_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            recent_valid <= '0;
        end else begin
            recent_valid <= {recent_valid[5:0], correct_valid};
        end
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------

    // report is a single-cycle pulse
    a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        adjust_valid |=> !adjust_valid)
        else $error("adjust_valid stayed high for more than one cycle");

    // strobes at least 8 cycles apart
    a_strobe_spacing: assert property (@(posedge clk) disable iff (reset)
        correct_valid |-> (recent_valid == '0))
        else $error("correct_valid repeated within 8 cycles");

    // every report comes from a strobe
    a_valid_cause: assert property (@(posedge clk) disable iff (reset)
        adjust_valid |-> $past(correct_valid, REPORT_DELAY))
        else $error("adjust_valid without a correct_valid 6 cycles earlier");

endmodule

bind sync_adjust_top sync_adjust_properties u_properties (
    .clk          (clk),
    .reset        (reset),
    .correct_valid(correct_valid),
    .adjust_valid (adjust_valid)
);

// ==== sim/tb_clock.sv ====
// free-running testbench clock with reset held high for the first RESET_CYCLES rising edges
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release 1 ns after an edge like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== hw/sync_adjust_top.sv ====
// correct_valid must repeat no sooner than every 8 cycles and adjust_valid follows it by 6 cycles
`timescale 1ns/1ps

module sync_adjust_top #(
    parameter int unsigned TIMER_WIDTH = sync_adjust_pkg::TIMER_WIDTH_DEFAULT,
    parameter int unsigned CYCLE_WIDTH = sync_adjust_pkg::CYCLE_WIDTH_DEFAULT,
    parameter int unsigned ERROR_WIDTH = sync_adjust_pkg::ERROR_WIDTH_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset,

    // correction strobe with its sampled times
    input  logic                   correct_valid,
    input  logic                   correct_override,
    input  logic [TIMER_WIDTH-1:0] correct_time,
    input  logic [TIMER_WIDTH-1:0] current_time,

    // published report
    output logic                   adjust_sign,
    output logic                   adjust_zero,
    output logic [ERROR_WIDTH+sync_adjust_pkg::ERROR_Q-1:0]        adjust_error,
    output logic [CYCLE_WIDTH+sync_adjust_pkg::LPF_GAIN_CYCLE-1:0] adjust_cycle,
    output logic                   adjust_valid
);

    // estimates toward the report stage
    estimate_if #(
        .CYCLE_WIDTH(CYCLE_WIDTH),
        .ERROR_WIDTH(ERROR_WIDTH)
    ) est_bus ();

    // ----------------------------------------
    // estimators
    // ----------------------------------------

    cycle_estimator #(
        .CYCLE_WIDTH(CYCLE_WIDTH)
    ) u_cycle_estimator (
        .clk          (clk),
        .reset        (reset),
        .correct_valid(correct_valid),
        .est          (est_bus.cycle_src)
    );

    drift_estimator #(
        .TIMER_WIDTH(TIMER_WIDTH),
        .ERROR_WIDTH(ERROR_WIDTH)
    ) u_drift_estimator (
        .clk             (clk),
        .reset           (reset),
        .correct_valid   (correct_valid),
        .correct_override(correct_override),
        .correct_time    (correct_time),
        .current_time    (current_time),
        .est             (est_bus.phase_src)
    );

    // ----------------------------------------
    // report
    // ----------------------------------------

    adjust_report #(
        .CYCLE_WIDTH(CYCLE_WIDTH),
        .ERROR_WIDTH(ERROR_WIDTH)
    ) u_adjust_report (
        .clk         (clk),
        .reset       (reset),
        .est         (est_bus.sink),
        .adjust_sign (adjust_sign),
        .adjust_zero (adjust_zero),
        .adjust_error(adjust_error),
        .adjust_cycle(adjust_cycle),
        .adjust_valid(adjust_valid)
    );

endmodule

// ==== hw/adjust_report.sv ====
// outputs are undefined until the first adjust_valid and adjust_cycle reads zero before any cycle estimate
`timescale 1ns/1ps

module adjust_report #(
    parameter int unsigned CYCLE_WIDTH = 16,
    parameter int unsigned ERROR_WIDTH = 32
) (
    input  logic                clk,
    input  logic                reset,
    estimate_if.sink            est,
    output logic                adjust_sign,
    output logic                adjust_zero,
    output logic [ERROR_WIDTH+sync_adjust_pkg::ERROR_Q-1:0]        adjust_error,
    output logic [CYCLE_WIDTH+sync_adjust_pkg::LPF_GAIN_CYCLE-1:0] adjust_cycle,
    output logic                adjust_valid
);

    localparam int unsigned EW = ERROR_WIDTH + sync_adjust_pkg::ERROR_Q;
    localparam int unsigned CB = CYCLE_WIDTH + sync_adjust_pkg::LPF_GAIN_CYCLE;

    // ----------------------------------------
    // candidate report
    // ----------------------------------------

    logic          next_sign;
    logic          next_zero;
    logic [EW-1:0] next_error;
    logic [CB-1:0] next_cycle;
    logic          changed;
    // something has gone out since reset
    logic          published;

    assign next_sign  = est.phase[EW-1];
    assign next_zero  = (est.phase == '0);
    // magnitude of the signed phase
    assign next_error = next_sign ? -est.phase : est.phase;
    assign next_cycle = est.cycle_ok ? est.cycle : '0;

    // compare against what was last published
    assign changed = !published
                   | (next_sign  != adjust_sign)
                   | (next_zero  != adjust_zero)
                   | (next_error != adjust_error)
                   | (next_cycle != adjust_cycle);

    // ----------------------------------------
    // publish
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            adjust_valid <= 1'b0;
            published    <= 1'b0;
        end else begin
            // single cycle pulse only on change
            adjust_valid <= est.phase_done & changed;
            if (est.phase_done) begin
                published <= 1'b1;
            end
        end
    end

    // unchanged values rewrite the same data
    always_ff @(posedge clk) begin
        if (est.phase_done) begin
            adjust_sign  <= next_sign;
            adjust_zero  <= next_zero;
            adjust_error <= next_error;
            adjust_cycle <= next_cycle;
        end
    end

endmodule

// ==== hw/drift_estimator.sv ====
// TIMER_WIDTH must not exceed ERROR_WIDTH and strobes must be at least ESTIMATE_LATENCY+3 cycles apart
`timescale 1ns/1ps

module drift_estimator #(
    parameter int unsigned TIMER_WIDTH = 32,
    parameter int unsigned ERROR_WIDTH = 32
) (
    input logic                   clk,
    input logic                   reset,
    input logic                   correct_valid,
    input logic                   correct_override,
    input logic [TIMER_WIDTH-1:0] correct_time,
    input logic [TIMER_WIDTH-1:0] current_time,
    estimate_if.phase_src         est
);

    localparam int unsigned EW      = ERROR_WIDTH + sync_adjust_pkg::ERROR_Q;
    localparam int unsigned LATENCY = sync_adjust_pkg::ESTIMATE_LATENCY;
    localparam int unsigned GAIN_X  = sync_adjust_pkg::LPF_GAIN_PHASE;
    localparam int unsigned GAIN_V  = sync_adjust_pkg::LPF_GAIN_PERIOD;

    // raw phase difference in timer units
    logic signed [TIMER_WIDTH-1:0] time_diff;
    assign time_diff = correct_time - current_time;

    // ----------------------------------------
    // stage markers
    // ----------------------------------------

    // bit k is high k+1 cycles after the strobe
    logic [LATENCY-1:0] stage;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= '0;
        end else begin
            stage <= {stage[LATENCY-2:0], correct_valid};
        end
    end

    // ----------------------------------------
    // estimator state
    // ----------------------------------------

    // phase observation of this strobe
    logic signed [EW-1:0] observe_x;
    // estimates from the previous strobe
    logic signed [EW-1:0] prev_x;
    logic signed [EW-1:0] prev_v;
    logic                 prev_x_ok;
    logic                 prev_v_ok;
    // phase predicted from previous phase plus period
    logic signed [EW-1:0] predict_x;
    logic                 predict_ok;
    // current phase estimate
    logic signed [EW-1:0] estimate_x;
    logic                 estimate_x_ok;
    // period observation and estimate
    logic signed [EW-1:0] observe_v;
    logic                 observe_v_ok;
    logic signed [EW-1:0] estimate_v;
    logic                 estimate_v_ok;

    // validity flags
    always_ff @(posedge clk) begin
        if (reset) begin
            prev_x_ok     <= 1'b0;
            prev_v_ok     <= 1'b0;
            predict_ok    <= 1'b0;
            estimate_x_ok <= 1'b0;
            observe_v_ok  <= 1'b0;
            estimate_v_ok <= 1'b0;
        end else begin
            // override forgets the history
            if (correct_valid) begin
                prev_x_ok <= estimate_x_ok & ~correct_override;
                prev_v_ok <= estimate_v_ok & ~correct_override;
            end
            if (stage[0]) begin
                predict_ok <= prev_x_ok & prev_v_ok;
            end
            if (stage[1]) begin
                estimate_x_ok <= 1'b1;
            end
            // a period needs two phase estimates
            if (stage[2]) begin
                observe_v_ok <= prev_x_ok;
            end
            // cleared again when no period was observed
            if (stage[3]) begin
                estimate_v_ok <= observe_v_ok;
            end
        end
    end

    // arithmetic
    always_ff @(posedge clk) begin
        // strobe cycle latches observation and history
        if (correct_valid) begin
            if (correct_override) begin
                observe_x <= '0;
            end else begin
                observe_x <= EW'(time_diff) <<< sync_adjust_pkg::ERROR_Q;
            end
            prev_x <= estimate_x;
            prev_v <= estimate_v;
        end

        // stage 1 predicts
        if (stage[0]) begin
            predict_x <= prev_x + prev_v;
        end

        // stage 2 blends prediction and observation
        if (stage[1]) begin
            if (predict_ok) begin
                estimate_x <= predict_x - (predict_x >>> GAIN_X) + (observe_x >>> GAIN_X);
            end else begin
                estimate_x <= observe_x;
            end
        end

        // stage 3 observes the period
        if (stage[2]) begin
            observe_v <= estimate_x - prev_x;
        end

        // stage 4 filters the period
        if (stage[3]) begin
            if (prev_v_ok) begin
                estimate_v <= prev_v - (prev_v >>> GAIN_V) + (observe_v >>> GAIN_V);
            end else begin
                // first period is taken as is
                estimate_v <= observe_v;
            end
        end
    end

    // phase settled two cycles before this
    assign est.phase      = estimate_x;
    assign est.phase_done = stage[LATENCY-1];

endmodule

// ==== hw/cycle_estimator.sv ====
// gaps longer than 2^CYCLE_WIDTH-1 cycles saturate the count and the first strobe only arms the counter
`timescale 1ns/1ps

module cycle_estimator #(
    parameter int unsigned CYCLE_WIDTH = 16
) (
    input logic       clk,
    input logic       reset,
    input logic       correct_valid,
    estimate_if.cycle_src est
);

    localparam int unsigned CYCLE_Q  = sync_adjust_pkg::LPF_GAIN_CYCLE;
    localparam int unsigned EST_BITS = CYCLE_WIDTH + CYCLE_Q;

    // ----------------------------------------
    // local cycle count
    // ----------------------------------------

    logic [CYCLE_WIDTH-1:0] count_cycle;
    // set once a strobe has been seen
    logic                   count_enable;
    logic                   count_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_cycle  <= '0;
            count_enable <= 1'b0;
        end else begin
            // hold at full scale on very long gaps
            if (count_cycle != '1) begin
                count_cycle <= count_cycle + 1'b1;
            end
            // restart at 1 so the strobe cycle itself counts
            if (correct_valid) begin
                count_cycle  <= CYCLE_WIDTH'(1);
                count_enable <= 1'b1;
            end
        end
    end

    // a full interval has elapsed
    assign count_valid = correct_valid & count_enable;

    // ----------------------------------------
    // low-pass filter
    // ----------------------------------------

    logic [EST_BITS-1:0] observe;
    logic                observe_valid;
    logic [EST_BITS-1:0] estimate;
    logic                estimate_ok;

    // control flags
    always_ff @(posedge clk) begin
        if (reset) begin
            observe_valid <= 1'b0;
            estimate_ok   <= 1'b0;
        end else begin
            observe_valid <= count_valid;
            if (observe_valid) begin
                estimate_ok <= 1'b1;
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        // observation in fixed point
        if (count_valid) begin
            observe <= EST_BITS'(count_cycle) << CYCLE_Q;
        end
        if (observe_valid) begin
            if (estimate_ok) begin
                // old minus old/2^N plus new/2^N
                estimate <= estimate - (estimate >> CYCLE_Q) + (observe >> CYCLE_Q);
            end else begin
                // first interval passes straight through
                estimate <= observe;
            end
        end
    end

    assign est.cycle    = estimate;
    assign est.cycle_ok = estimate_ok;

endmodule

// ==== hw/estimate_if.sv ====
// carries final estimates only with no back-pressure and cycle must be stable whenever phase_done is high
`timescale 1ns/1ps

interface estimate_if #(
    parameter int unsigned CYCLE_WIDTH = 16,
    parameter int unsigned ERROR_WIDTH = 32
);

    // cycle estimate keeps LPF_GAIN_CYCLE fraction bits
    localparam int unsigned CYCLE_BITS = CYCLE_WIDTH + sync_adjust_pkg::LPF_GAIN_CYCLE;
    // phase estimate keeps ERROR_Q fraction bits
    localparam int unsigned PHASE_BITS = ERROR_WIDTH + sync_adjust_pkg::ERROR_Q;

    logic        [CYCLE_BITS-1:0] cycle;
    logic                         cycle_ok;
    logic signed [PHASE_BITS-1:0] phase;
    logic                         phase_done;

    // cycle side
    modport cycle_src (output cycle, output cycle_ok);

    // phase side
    modport phase_src (output phase, output phase_done);

    // report stage reads everything
    modport sink (input cycle, input cycle_ok, input phase, input phase_done);

endinterface

// ==== hw/sync_adjust_pkg.sv ====
// filter gains are plain shift counts and ERROR_Q should be at least the phase and period gains
package sync_adjust_pkg;

    // ----------------------------------------
    // default widths
    // ----------------------------------------

    // timer values as seen on correct_time and current_time
    localparam int unsigned TIMER_WIDTH_DEFAULT = 32;

    // local cycle counter between corrections
    localparam int unsigned CYCLE_WIDTH_DEFAULT = 16;

    // integer part of the error arithmetic
    localparam int unsigned ERROR_WIDTH_DEFAULT = 32;

    // ----------------------------------------
    // fixed point
    // ----------------------------------------

    // fractional bits appended to phase and period errors
    localparam int unsigned ERROR_Q = 8;

    // ----------------------------------------
    // filter gains
    // ----------------------------------------

    // update weight is 1/2^N for each gain
    // cycle gain doubles as the fraction of the cycle estimate
    localparam int unsigned LPF_GAIN_CYCLE  = 2;
    localparam int unsigned LPF_GAIN_PERIOD = 2;
    localparam int unsigned LPF_GAIN_PHASE  = 2;

    // ----------------------------------------
    // timing
    // ----------------------------------------

    // correct_valid to phase_done in clock cycles
    localparam int unsigned ESTIMATE_LATENCY = 5;

endpackage
